// File: Makefile
TOP = pa_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// File: build.f
rtl/pa_data_pkg.sv
rtl/pa_ctrl_pkg.sv
rtl/pa_w_mux.sv
rtl/pa_a_bus.sv
rtl/pa_alu.sv
rtl/pa_regs.sv
rtl/pa.sv
tb/pa_sva.sv
tb/pa_tb.sv

// File: rtl/pa.sv
// P-A arithmetic unit top: W and A buses, ALU, registers, data-bus driver and address match
`timescale 1ns/1ps
`default_nettype none

module pa #(
	parameter logic [0:pa_data_pkg::word_w-1] ic_start = 16'h0000
) (
	input  logic                             clk,
	input  logic                             arst_n,
	// data words
	input  logic [0:pa_data_pkg::word_w-1]   ir,
	input  logic [0:pa_data_pkg::word_w-1]   ki,
	input  logic [0:pa_data_pkg::word_w-1]   rdt,
	input  logic [0:pa_data_pkg::word_w-1]   kl,
	input  logic [0:pa_data_pkg::word_w-1]   l,
	// bus selects
	input  logic [pa_ctrl_pkg::w_sel_w-1:0]  w_sel,
	input  logic [pa_ctrl_pkg::a_sel_w-1:0]  a_sel,
	input  logic                             blank_hi,
	input  logic                             blank_lo,
	input  logic [pa_ctrl_pkg::alu_op_w-1:0] alu_op,
	input  logic                             carry_in,
	// register enables
	input  logic                             ac_load,
	input  logic                             at_load,
	input  logic                             at_shift,
	input  logic                             at_shift_in,
	input  logic                             ar_load,
	input  logic                             ar_inc,
	input  logic                             ar_dec4,
	input  logic                             ic_load,
	input  logic                             ic_inc,
	input  logic                             ic_off,
	input  logic                             wzi_load,
	// address and data bus
	input  logic                             ar_to_addr,
	input  logic                             ic_to_addr,
	input  logic                             bank_bit,
	input  logic                             dt_drive,
	output logic [0:pa_data_pkg::word_w-1]   w,
	output logic [0:pa_data_pkg::word_w-1]   ddt,
	output logic [0:pa_data_pkg::word_w-1]   f,
	output logic                             carry,
	output logic                             zero,
	output logic [0:pa_data_pkg::word_w-1]   at,
	output logic [0:pa_data_pkg::word_w-1]   ac,
	output logic                             wzi,
	output logic [0:pa_data_pkg::word_w-1]   addr,
	output logic                             key_match
);
	import pa_data_pkg::*;

	logic [0:word_w-1] a;
	logic [0:word_w-1] ar;
	logic [0:word_w-1] ic;

	pa_w_mux i_w_mux (
		.w_sel(w_sel), .blank_hi(blank_hi), .blank_lo(blank_lo),
		.ir(ir), .kl(kl), .rdt(rdt), .ki(ki),
		.at(at), .ac(ac), .a(a), .w(w)
	);

	pa_a_bus i_a_bus (
		.a_sel(a_sel), .l(l), .ir(ir), .ar(ar), .ic(ic), .a(a)
	);

	pa_alu i_alu (
		.alu_op(alu_op), .carry_in(carry_in), .a(a), .ac(ac),
		.f(f), .carry(carry), .zero(zero)
	);

	pa_regs #(
		.ic_start(ic_start)
	) i_regs (
		.clk(clk), .arst_n(arst_n), .w(w), .f(f), .zero(zero),
		.ac_load(ac_load), .at_load(at_load), .at_shift(at_shift),
		.at_shift_in(at_shift_in), .ar_load(ar_load), .ar_inc(ar_inc),
		.ar_dec4(ar_dec4), .ic_load(ic_load), .ic_inc(ic_inc), .ic_off(ic_off),
		.wzi_load(wzi_load), .ac(ac), .at(at), .ar(ar), .ic(ic), .wzi(wzi)
	);

	// W onto the data bus only while driving
	assign ddt = w & {word_w{dt_drive}};

	// both selects set gives the OR of AR and IC
	assign addr = (ar & {word_w{ar_to_addr}}) | (ic & {word_w{ic_to_addr}});

	// bank bit replaces the top address bit in the key-lock compare
	assign key_match = ({bank_bit, addr[1:word_w-1]} == kl);

endmodule

`default_nettype wire

// File: rtl/pa_a_bus.sv
// A bus multiplexer: L bus, short IR argument, AR or IC onto the ALU input
`timescale 1ns/1ps
`default_nettype none

module pa_a_bus (
	input  logic [pa_ctrl_pkg::a_sel_w-1:0] a_sel,
	input  logic [0:pa_data_pkg::word_w-1]  l,
	input  logic [0:pa_data_pkg::word_w-1]  ir,
	input  logic [0:pa_data_pkg::word_w-1]  ar,
	input  logic [0:pa_data_pkg::word_w-1]  ic,
	output logic [0:pa_data_pkg::word_w-1]  a
);
	import pa_data_pkg::*;
	import pa_ctrl_pkg::*;

	ir_word_u            ir_u;
	logic [0:word_w-1]   irs_mag;
	logic [0:word_w-1]   irs;

	assign ir_u = ir;

	// zero-extended magnitude of the short argument
	assign irs_mag = {{(word_w - $bits(ir_u.sht.mag)){1'b0}}, ir_u.sht.mag};

	// two's complement when neg is set
	assign irs = ir_u.sht.neg ? (~irs_mag + word_w'(1)) : irs_mag;

	always_comb begin
		case (a_sel)
			A_L:     a = l;
			A_IRS:   a = irs;
			A_AR:    a = ar;
			default: a = ic;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/pa_alu.sv
// P-A ALU: add, subtract, logic and pass operations on A and AC with carry and zero flags
`timescale 1ns/1ps
`default_nettype none

module pa_alu (
	input  logic [pa_ctrl_pkg::alu_op_w-1:0] alu_op,
	input  logic                             carry_in,
	input  logic [0:pa_data_pkg::word_w-1]   a,
	input  logic [0:pa_data_pkg::word_w-1]   ac,
	output logic [0:pa_data_pkg::word_w-1]   f,
	output logic                             carry,
	output logic                             zero
);
	import pa_data_pkg::*;
	import pa_ctrl_pkg::*;

	// bit 0 of sum is the carry out
	logic [0:word_w]   sum;
	logic [0:word_w]   a_ext;
	logic [0:word_w]   ac_ext;
	logic [0:word_w]   cin_ext;
	logic [0:word_w]   ncin_ext;
	logic              arith;

	assign a_ext    = {1'b0, a};
	assign ac_ext   = {1'b0, ac};
	assign cin_ext  = {{word_w{1'b0}}, carry_in};
	assign ncin_ext = {{word_w{1'b0}}, ~carry_in};

	always_comb begin
		sum   = '0;
		arith = 1'b0;
		case (alu_op)
			OP_ADD: begin
				sum   = a_ext + ac_ext + cin_ext;
				arith = 1'b1;
			end
			OP_SUB: begin
				// a + ~ac + 1 - carry_in, carry out means no borrow
				sum   = a_ext + {1'b0, ~ac} + ncin_ext;
				arith = 1'b1;
			end
			OP_INC: begin
				sum   = a_ext + (word_w + 1)'(1);
				arith = 1'b1;
			end
			default: begin
				sum   = '0;
				arith = 1'b0;
			end
		endcase
	end

	always_comb begin
		case (alu_op)
			OP_AND:     f = a & ac;
			OP_OR:      f = a | ac;
			OP_XOR:     f = a ^ ac;
			OP_PASS_A:  f = a;
			OP_PASS_AC: f = ac;
			default:    f = sum[1:word_w];
		endcase
	end

	// no carry for logic and pass ops
	assign carry = arith & sum[0];
	assign zero  = ~|f;

endmodule

`default_nettype wire

// File: rtl/pa_ctrl_pkg.sv
// P-A control package: select codes for the W and A buses and the ALU operation codes
`default_nettype none

package pa_ctrl_pkg;

	localparam int w_sel_w  = 3;
	localparam int a_sel_w  = 2;
	localparam int alu_op_w = 3;

	// W bus sources
	localparam logic [w_sel_w-1:0] W_IR   = 3'd0;
	localparam logic [w_sel_w-1:0] W_KL   = 3'd1;
	localparam logic [w_sel_w-1:0] W_RDT  = 3'd2;
	// high byte zero, low byte takes AC high byte
	localparam logic [w_sel_w-1:0] W_SWAP = 3'd3;
	localparam logic [w_sel_w-1:0] W_KI   = 3'd4;
	localparam logic [w_sel_w-1:0] W_AT   = 3'd5;
	localparam logic [w_sel_w-1:0] W_AC   = 3'd6;
	localparam logic [w_sel_w-1:0] W_A    = 3'd7;

	// A bus sources
	localparam logic [a_sel_w-1:0] A_L   = 2'd0;
	localparam logic [a_sel_w-1:0] A_IRS = 2'd1;
	localparam logic [a_sel_w-1:0] A_AR  = 2'd2;
	localparam logic [a_sel_w-1:0] A_IC  = 2'd3;

	// ALU operations
	localparam logic [alu_op_w-1:0] OP_ADD     = 3'd0;
	localparam logic [alu_op_w-1:0] OP_SUB     = 3'd1;
	localparam logic [alu_op_w-1:0] OP_AND     = 3'd2;
	localparam logic [alu_op_w-1:0] OP_OR      = 3'd3;
	localparam logic [alu_op_w-1:0] OP_XOR     = 3'd4;
	localparam logic [alu_op_w-1:0] OP_PASS_A  = 3'd5;
	localparam logic [alu_op_w-1:0] OP_PASS_AC = 3'd6;
	localparam logic [alu_op_w-1:0] OP_INC     = 3'd7;

endpackage

`default_nettype wire

// File: rtl/pa_data_pkg.sv
// P-A data package: machine word width and the two decodings of the instruction word
`default_nettype none

package pa_data_pkg;

	// machine word, bit 0 is the most significant bit
	localparam int word_w = 16;

	// register-form decoding of IR
	typedef struct packed {
		logic [0:5] op;
		logic       d;
		logic [0:2] ra;
		logic [0:2] rb;
		logic [0:2] rc;
	} ir_field_view_t;

	// short-argument decoding of IR
	// mag is the 9-bit magnitude, neg makes it negative
	typedef struct packed {
		logic [0:5] op;
		logic       neg;
		logic [0:8] mag;
	} ir_short_view_t;

	// one IR word, read either way
	typedef union packed {
		ir_field_view_t fld;
		ir_short_view_t sht;
	} ir_word_u;

endpackage

`default_nettype wire

// File: rtl/pa_regs.sv
// P-A working registers: AC, AT with right shift, AR and IC counters, captured zero flag
`timescale 1ns/1ps
`default_nettype none

module pa_regs #(
	parameter logic [0:pa_data_pkg::word_w-1] ic_start = 16'h0000
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic [0:pa_data_pkg::word_w-1]  w,
	input  logic [0:pa_data_pkg::word_w-1]  f,
	input  logic                            zero,
	input  logic                            ac_load,
	input  logic                            at_load,
	input  logic                            at_shift,
	input  logic                            at_shift_in,
	input  logic                            ar_load,
	input  logic                            ar_inc,
	input  logic                            ar_dec4,
	input  logic                            ic_load,
	input  logic                            ic_inc,
	input  logic                            ic_off,
	input  logic                            wzi_load,
	output logic [0:pa_data_pkg::word_w-1]  ac,
	output logic [0:pa_data_pkg::word_w-1]  at,
	output logic [0:pa_data_pkg::word_w-1]  ar,
	output logic [0:pa_data_pkg::word_w-1]  ic,
	output logic                            wzi
);
	import pa_data_pkg::*;

	// accumulator
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ac <= '0;
		end else if (ac_load) begin
			ac <= w;
		end
	end

	// AT takes the ALU result, or shifts towards bit 15
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			at <= '0;
		end else if (at_load) begin
			at <= f;
		end else if (at_shift) begin
			at <= {at_shift_in, at[0:word_w-2]};
		end
	end

	// address register, counts wrap modulo 2^16
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ar <= '0;
		end else if (ar_load) begin
			ar <= w;
		end else if (ar_inc) begin
			ar <= ar + word_w'(1);
		end else if (ar_dec4) begin
			ar <= ar - word_w'(4);
		end
	end

	// instruction counter
	// ic_off restarts the program from ic_start
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ic <= ic_start;
		end else if (ic_off) begin
			ic <= ic_start;
		end else if (ic_load) begin
			ic <= w;
		end else if (ic_inc) begin
			ic <= ic + word_w'(1);
		end
	end

	// zero flag of the current ALU result
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wzi <= 1'b0;
		end else if (wzi_load) begin
			wzi <= zero;
		end
	end

endmodule

`default_nettype wire

// File: rtl/pa_w_mux.sv
// W bus multiplexer: picks one of eight sources per byte and blanks either byte
`timescale 1ns/1ps
`default_nettype none

module pa_w_mux (
	input  logic [pa_ctrl_pkg::w_sel_w-1:0] w_sel,
	input  logic                            blank_hi,
	input  logic                            blank_lo,
	input  logic [0:pa_data_pkg::word_w-1]  ir,
	input  logic [0:pa_data_pkg::word_w-1]  kl,
	input  logic [0:pa_data_pkg::word_w-1]  rdt,
	input  logic [0:pa_data_pkg::word_w-1]  ki,
	input  logic [0:pa_data_pkg::word_w-1]  at,
	input  logic [0:pa_data_pkg::word_w-1]  ac,
	input  logic [0:pa_data_pkg::word_w-1]  a,
	output logic [0:pa_data_pkg::word_w-1]  w
);
	import pa_ctrl_pkg::*;

	always_comb begin
		// high byte, bits 0..7
		if (blank_hi) w[0:7] = 8'd0;
		else case (w_sel)
			W_IR:    w[0:7] = ir[0:7];
			W_KL:    w[0:7] = kl[0:7];
			W_RDT:   w[0:7] = rdt[0:7];
			W_SWAP:  w[0:7] = 8'd0;
			W_KI:    w[0:7] = ki[0:7];
			W_AT:    w[0:7] = at[0:7];
			W_AC:    w[0:7] = ac[0:7];
			default: w[0:7] = a[0:7];
		endcase

		// low byte, swap path brings AC high byte down
		if (blank_lo) w[8:15] = 8'd0;
		else case (w_sel)
			W_IR:    w[8:15] = ir[8:15];
			W_KL:    w[8:15] = kl[8:15];
			W_RDT:   w[8:15] = rdt[8:15];
			W_SWAP:  w[8:15] = ac[0:7];
			W_KI:    w[8:15] = ki[8:15];
			W_AT:    w[8:15] = at[8:15];
			W_AC:    w[8:15] = ac[8:15];
			default: w[8:15] = a[8:15];
		endcase
	end

endmodule

`default_nettype wire

// File: tb/pa_sva.sv
// P-A register and key-lock checks, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module pa_sva #(
	parameter logic [0:pa_data_pkg::word_w-1] ic_start = 16'h0000
) (
	input logic                           clk,
	input logic                           arst_n,
	input logic [0:pa_data_pkg::word_w-1] w,
	input logic [0:pa_data_pkg::word_w-1] ar,
	input logic [0:pa_data_pkg::word_w-1] ic,
	input logic [0:pa_data_pkg::word_w-1] kl,
	input logic                           ar_load,
	input logic                           ar_inc,
	input logic                           ar_dec4,
	input logic                           ic_load,
	input logic                           ic_inc,
	input logic                           ic_off,
	input logic                           ar_to_addr,
	input logic                           ic_to_addr,
	input logic                           bank_bit,
	input logic                           key_match
);
	import pa_data_pkg::*;

	logic [0:word_w-1] ar_next;
	logic [0:word_w-1] ic_next;
	logic [0:word_w-1] addr_ref;

	// next values by priority
	always_comb begin
		if (ar_load) ar_next = w;
		else if (ar_inc) ar_next = ar + 16'd1;
		else if (ar_dec4) ar_next = ar - 16'd4;
		else ar_next = ar;
		if (ic_off) ic_next = ic_start;
		else if (ic_load) ic_next = w;
		else if (ic_inc) ic_next = ic + 16'd1;
		else ic_next = ic;
	end

	// address word rebuilt from the registers and their selects
	assign addr_ref = (ar_to_addr ? ar : '0) | (ic_to_addr ? ic : '0);

	ar_update: assert property (@(posedge clk) disable iff (!arst_n)
		$past(arst_n) |-> ar == $past(ar_next))
		else $error("AR did not follow load, increment and decrement priority");

	ic_update: assert property (@(posedge clk) disable iff (!arst_n)
		$past(arst_n) |-> ic == $past(ic_next))
		else $error("IC did not follow restart, load and increment priority");

	ic_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> ic == ic_start)
		else $error("IC not at its start address after reset");

	key_compare: assert property (@(posedge clk)
		key_match == (kl[0] == bank_bit && kl[1:word_w-1] == addr_ref[1:word_w-1]))
		else $error("key_match disagrees with the bank and address compare");

endmodule

bind pa pa_sva #(.ic_start(ic_start)) i_pa_sva (
	.clk(clk), .arst_n(arst_n), .w(w), .ar(ar), .ic(ic), .kl(kl),
	.ar_load(ar_load), .ar_inc(ar_inc), .ar_dec4(ar_dec4), .ic_load(ic_load),
	.ic_inc(ic_inc), .ic_off(ic_off), .ar_to_addr(ar_to_addr), .ic_to_addr(ic_to_addr),
	.bank_bit(bank_bit), .key_match(key_match)
);

`default_nettype wire

// File: tb/pa_tb.sv
// P-A testbench: LFSR stimulus checked against a shadow model of the arithmetic unit
`timescale 1ns/1ps
`default_nettype none

module pa_tb;
	import pa_data_pkg::*;
	import pa_ctrl_pkg::*;

	localparam logic [0:15] ic_start_tb = 16'h0100;
	// reset, reset check, w bus, alu, loads, ic_off, counters, address, zero capture
	localparam int stim_cycles = 8 + 1 + 32 + 64 + 40 + 2 + 64 + 16 + 16;

	logic        clk;
	logic        arst_n;
	logic [0:15] ir, ki, rdt, kl, l;
	logic [2:0]  w_sel, alu_op;
	logic [1:0]  a_sel;
	logic        blank_hi, blank_lo, carry_in, dt_drive, bank_bit;
	logic        ar_to_addr, ic_to_addr;
	logic        ac_load, at_load, at_shift, at_shift_in, ar_load, ar_inc, ar_dec4;
	logic        ic_load, ic_inc, ic_off, wzi_load;
	logic [0:15] w, ddt, f, at, ac, addr;
	logic        carry, zero, wzi, key_match;

	// shadow registers, always one step ahead of the next check
	logic [0:15] model_ac, model_at, model_ar, model_ic;
	logic        model_wzi;
	logic [15:0] lfsr;
	ir_word_u    iw;
	int          cycle_count;

	pa #(.ic_start(ic_start_tb)) i_pa (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[14:0], fb};
		end
		return r;
	endfunction

	function automatic logic [0:15] a_expected();
		ir_word_u    u;
		logic [0:15] mag;
		logic [0:15] r;
		u = ir;
		mag = {7'd0, u.sht.mag};
		case (a_sel)
			A_L:     r = l;
			A_IRS:   r = u.sht.neg ? 16'd0 - mag : mag;
			A_AR:    r = model_ar;
			default: r = model_ic;
		endcase
		return r;
	endfunction

	// whole word first, blanking afterwards
	function automatic logic [0:15] w_expected(input logic [0:15] a_val);
		logic [0:15] r;
		case (w_sel)
			W_IR:    r = ir;
			W_KL:    r = kl;
			W_RDT:   r = rdt;
			W_SWAP:  r = {8'h00, model_ac[0:7]};
			W_KI:    r = ki;
			W_AT:    r = model_at;
			W_AC:    r = model_ac;
			default: r = a_val;
		endcase
		if (blank_hi) r[0:7] = 8'h00;
		if (blank_lo) r[8:15] = 8'h00;
		return r;
	endfunction

	// bit 0 is carry, bits 1..16 the result
	function automatic logic [0:16] alu_expected(input logic [0:15] a_val);
		int          t;
		logic [0:16] r;
		case (alu_op)
			OP_ADD:  t = int'(a_val) + int'(model_ac) + int'(carry_in);
			OP_SUB:  t = int'(a_val) - int'(model_ac) - int'(carry_in);
			OP_INC:  t = int'(a_val) + 1;
			default: t = 0;
		endcase
		case (alu_op)
			OP_ADD, OP_INC: r = {t > 65535, t[15:0]};
			// no borrow means carry
			OP_SUB:     r = {t >= 0, t[15:0]};
			OP_AND:     r = {1'b0, a_val & model_ac};
			OP_OR:      r = {1'b0, a_val | model_ac};
			OP_XOR:     r = {1'b0, a_val ^ model_ac};
			OP_PASS_A:  r = {1'b0, a_val};
			default:    r = {1'b0, model_ac};
		endcase
		return r;
	endfunction

	task automatic compare_word(input string name, input logic [0:15] exp_v,
		input logic [0:15] act_v);
		assert (act_v === exp_v) else begin
			$display("ERR %s expected %h actual %h", name, exp_v, act_v);
			$display("Test FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	// check at the falling edge, then advance the shadows past the rising edge
	task automatic run_cycle(input string name);
		logic [0:15] a_e, w_e, addr_e;
		logic [0:16] alu_e;
		@(negedge clk);
		a_e = a_expected();
		w_e = w_expected(a_e);
		alu_e = alu_expected(a_e);
		addr_e = (ar_to_addr ? model_ar : 16'h0) | (ic_to_addr ? model_ic : 16'h0);
		compare_word({name, " w"}, w_e, w);
		compare_word({name, " ddt"}, dt_drive ? w_e : 16'h0, ddt);
		compare_word({name, " f"}, alu_e[1:16], f);
		compare_word({name, " carry"}, {15'd0, alu_e[0]}, {15'd0, carry});
		compare_word({name, " zero"}, {15'd0, alu_e[1:16] == 16'h0}, {15'd0, zero});
		compare_word({name, " ac"}, model_ac, ac);
		compare_word({name, " at"}, model_at, at);
		compare_word({name, " wzi"}, {15'd0, model_wzi}, {15'd0, wzi});
		compare_word({name, " addr"}, addr_e, addr);
		compare_word({name, " key_match"}, {15'd0, {bank_bit, addr_e[1:15]} == kl},
			{15'd0, key_match});
		if (ac_load) model_ac = w_e;
		if (at_load) model_at = alu_e[1:16];
		else if (at_shift) model_at = {at_shift_in, model_at[0:14]};
		if (ar_load) model_ar = w_e;
		else if (ar_inc) model_ar = model_ar + 16'd1;
		else if (ar_dec4) model_ar = model_ar - 16'd4;
		if (ic_off) model_ic = ic_start_tb;
		else if (ic_load) model_ic = w_e;
		else if (ic_inc) model_ic = model_ic + 16'd1;
		if (wzi_load) model_wzi = (alu_e[1:16] == 16'h0);
		@(posedge clk);
		#1;
	endtask

	task automatic drive_random();
		ir = rand_bits(16);
		ki = rand_bits(16);
		rdt = rand_bits(16);
		kl = rand_bits(16);
		l = rand_bits(16);
		w_sel = 3'(rand_bits(3));
		a_sel = 2'(rand_bits(2));
		alu_op = 3'(rand_bits(3));
		carry_in = rand_bits(1) != 0;
		dt_drive = rand_bits(1) != 0;
		bank_bit = rand_bits(1) != 0;
	endtask

	task automatic clear_controls();
		{ac_load, at_load, at_shift, at_shift_in, ar_load, ar_inc, ar_dec4} = '0;
		{ic_load, ic_inc, ic_off, wzi_load} = '0;
		{blank_hi, blank_lo, ar_to_addr, ic_to_addr} = '0;
	endtask

	initial begin
		lfsr = 16'd45;
		arst_n = 1'b0;
		clear_controls();
		drive_random();
		model_ac = '0;
		model_at = '0;
		model_ar = '0;
		model_ic = ic_start_tb;
		model_wzi = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		ic_to_addr = 1'b1;
		run_cycle("reset");

		// every w bus source with every blank pair
		for (int i = 0; i < 32; i++) begin
			drive_random();
			clear_controls();
			w_sel = 3'(i >> 2);
			blank_hi = i[1];
			blank_lo = i[0];
			ac_load = rand_bits(1) != 0;
			at_load = rand_bits(1) != 0;
			run_cycle("w_bus");
		end

		// op, a bus source, sign of the short argument
		for (int i = 0; i < 64; i++) begin
			drive_random();
			clear_controls();
			alu_op = 3'(i >> 3);
			a_sel = 2'(i >> 1);
			iw = ir;
			iw.sht.neg = i[0];
			ir = iw;
			at_load = 1'b1;
			ac_load = rand_bits(1) != 0;
			ar_load = rand_bits(1) != 0;
			ic_load = rand_bits(2) == 0;
			wzi_load = rand_bits(1) != 0;
			run_cycle("alu");
		end

		// loads, shifts and holds with overlapping enables
		for (int i = 0; i < 40; i++) begin
			drive_random();
			clear_controls();
			iw.fld.op = 6'(rand_bits(6));
			iw.fld.d = rand_bits(1) != 0;
			iw.fld.ra = 3'(rand_bits(3));
			iw.fld.rb = 3'(rand_bits(3));
			iw.fld.rc = 3'(rand_bits(3));
			ir = iw;
			ac_load = rand_bits(1) != 0;
			at_load = rand_bits(2) == 0;
			at_shift = rand_bits(1) != 0;
			at_shift_in = rand_bits(1) != 0;
			ar_load = rand_bits(1) != 0;
			ar_inc = rand_bits(1) != 0;
			ar_dec4 = rand_bits(1) != 0;
			ic_load = rand_bits(1) != 0;
			ic_inc = rand_bits(1) != 0;
			ic_off = rand_bits(3) == 0;
			ar_to_addr = i[0];
			ic_to_addr = !i[0];
			run_cycle("loads");
		end
		clear_controls();
		ic_off = 1'b1;
		ic_to_addr = 1'b1;
		run_cycle("ic_off");
		ic_off = 1'b0;
		run_cycle("ic_off");

		// start just below the wrap point
		clear_controls();
		w_sel = W_RDT;
		rdt = 16'hFFFD;
		ar_load = 1'b1;
		ic_load = 1'b1;
		run_cycle("counters");
		for (int i = 0; i < 63; i++) begin
			drive_random();
			clear_controls();
			ar_inc = (i < 32) ? rand_bits(2) != 0 : rand_bits(2) == 0;
			ar_dec4 = rand_bits(1) != 0;
			ic_inc = rand_bits(2) != 0;
			ar_to_addr = i[0];
			ic_to_addr = !i[0];
			run_cycle("counters");
		end

		// kl equal to the expected compare word, or off in the bank bit or elsewhere
		clear_controls();
		for (int i = 0; i < 16; i++) begin
			drive_random();
			ar_to_addr = i[0];
			ic_to_addr = i[1];
			kl = (ar_to_addr ? model_ar : 16'h0) | (ic_to_addr ? model_ic : 16'h0);
			kl[0] = bank_bit;
			if (!i[2]) kl = kl ^ (i[3] ? 16'h8000 : (rand_bits(16) | 16'h0001));
			run_cycle("addr");
		end

		// xor with ac gives zero, pass of a nonzero word does not
		for (int i = 0; i < 16; i++) begin
			drive_random();
			a_sel = A_L;
			alu_op = i[0] ? OP_PASS_A : OP_XOR;
			l = i[0] ? (rand_bits(16) | 16'h0010) : model_ac;
			wzi_load = !i[1];
			run_cycle("zero");
		end

		$display("Test OK");
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < 4 * stim_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: tests did not finish within %0d cycles", 4 * stim_cycles);
		$display("Test FAILED");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire
